// File: logic/board_bus_pkg.sv
package board_bus_pkg;

    // Address map, byte addresses on the requester bus
    localparam logic [31:0] RAM_BASE     = 32'h0000_1000;
    localparam int unsigned RAM_WORDS    = 1024;
    localparam logic [31:0] SD_BUF_BASE  = 32'h0000_E000;
    localparam int unsigned SD_BUF_BYTES = 512;
    localparam logic [31:0] KEY_ADDR     = 32'h0000_F000;
    localparam logic [31:0] UART_ADDR    = 32'h0000_F004;
    localparam logic [31:0] SD_ADDR_REG  = 32'h0000_F008;
    localparam logic [31:0] SD_READ_REG  = 32'h0000_F00C;
    localparam logic [31:0] SD_READY_REG = 32'h0000_F010;
    localparam logic [31:0] SD_AVAIL_REG = 32'h0000_F014;

    // Interrupt vector raised by a key press
    localparam logic [3:0] KEY_IRQ = 4'd1;

    // Load kinds, same encoding the processor drives
    typedef enum logic [2:0] {
        LOAD_B  = 3'b000,
        LOAD_H  = 3'b001,
        LOAD_W  = 3'b010,
        LOAD_BU = 3'b100,
        LOAD_HU = 3'b101
    } load_kind_e;

    // Nine regions, so four bits are needed
    typedef enum logic [3:0] {
        REG_NONE,
        REG_RAM,
        REG_KEY,
        REG_UART,
        REG_SD_ADDR,
        REG_SD_READ,
        REG_SD_READY,
        REG_SD_AVAIL,
        REG_SD_BUF
    } region_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        read;
        logic        write;
        load_kind_e  kind;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        done;
    } bus_rsp_t;

    typedef struct packed {
        region_e     region;
        logic [11:0] offset;
        logic [1:0]  lane;
        load_kind_e  kind;
        logic [31:0] wdata;
        logic        read;
        logic        write;
    } dec_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] ascii;
    } key_in_t;

    typedef struct packed {
        logic       byte_valid;
        logic [7:0] byte_data;
        logic       ready;
    } sd_in_t;

    typedef struct packed {
        logic [31:0] sector;
        logic        start;
    } sd_cmd_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } uart_out_t;

endpackage

// File: logic/bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder import board_bus_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  bus_req_t bus_req,
    output dec_req_t dec
);

    region_e     region_c;
    logic [31:0] base_c;
    logic [31:0] rel_addr;

    // Classify the address against the map
    always_comb begin
        region_c = REG_NONE;
        // Single registers subtract their own address, giving offset zero
        base_c   = bus_req.addr;
        if (bus_req.addr >= RAM_BASE && bus_req.addr < RAM_BASE + RAM_WORDS * 4) begin
            region_c = REG_RAM;
            base_c   = RAM_BASE;
        end else if (bus_req.addr >= SD_BUF_BASE &&
                     bus_req.addr < SD_BUF_BASE + SD_BUF_BYTES) begin
            region_c = REG_SD_BUF;
            base_c   = SD_BUF_BASE;
        end else begin
            case (bus_req.addr)
                KEY_ADDR:     region_c = REG_KEY;
                UART_ADDR:    region_c = REG_UART;
                SD_ADDR_REG:  region_c = REG_SD_ADDR;
                SD_READ_REG:  region_c = REG_SD_READ;
                SD_READY_REG: region_c = REG_SD_READY;
                SD_AVAIL_REG: region_c = REG_SD_AVAIL;
                default:      region_c = REG_NONE;
            endcase
        end
    end

    assign rel_addr = bus_req.addr - base_c;

    // One register stage between the bus and the devices
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            dec <= '0;
        end else begin
            dec.region <= region_c;
            dec.offset <= rel_addr[11:0];
            dec.lane   <= bus_req.addr[1:0];
            dec.kind   <= bus_req.kind;
            dec.wdata  <= bus_req.wdata;
            dec.read   <= bus_req.read;
            dec.write  <= bus_req.write;
        end
    end

endmodule

// File: logic/word_ram.sv
`timescale 1ns/1ns

module word_ram import board_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  dec_req_t    dec,
    output logic [31:0] rdata
);

    logic [31:0] mem [RAM_WORDS];
    logic [9:0]  word_idx;
    logic        ram_wr;

    // Word index from the byte offset in the region
    assign word_idx = dec.offset[11:2];
    assign ram_wr   = dec.write && (dec.region == REG_RAM);

    // Port with whole-word write and registered read
    always_ff @(posedge CLOCK_50) begin
        if (ram_wr) begin
            mem[word_idx] <= dec.wdata;
        end
        rdata <= mem[word_idx];
    end

endmodule

// File: logic/sd_sector_buffer.sv
`timescale 1ns/1ns

module sd_sector_buffer import board_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  dec_req_t    dec,
    input  sd_in_t      sd_in,
    output sd_cmd_t     sd_cmd,
    output logic [31:0] rdata
);

    logic [7:0]  buf_mem [SD_BUF_BYTES];
    logic [31:0] sector_q;
    logic        start_q;
    logic        avail_q;
    logic [8:0]  byte_idx;
    logic        addr_wr;
    logic        start_wr;

    assign addr_wr  = dec.write && (dec.region == REG_SD_ADDR);
    assign start_wr = dec.write && (dec.region == REG_SD_READ);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sector_q <= '0;
            start_q  <= 1'b0;
            avail_q  <= 1'b0;
            byte_idx <= '0;
        end else begin
            start_q <= start_wr;
            if (addr_wr) begin
                sector_q <= dec.wdata;
            end
            // A new read request restarts the fill
            if (start_wr) begin
                avail_q  <= 1'b0;
                byte_idx <= '0;
            end else if (sd_in.byte_valid) begin
                if (byte_idx == 9'(SD_BUF_BYTES - 1)) begin
                    byte_idx <= '0;
                    avail_q  <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 9'd1;
                end
            end
        end
    end

    // Byte capture and read port
    always_ff @(posedge CLOCK_50) begin
        if (sd_in.byte_valid && !start_wr) begin
            buf_mem[byte_idx] <= sd_in.byte_data;
        end
        case (dec.region)
            REG_SD_BUF:   rdata <= {24'd0, buf_mem[dec.offset[8:0]]};
            REG_SD_READY: rdata <= {31'd0, sd_in.ready};
            REG_SD_AVAIL: rdata <= {31'd0, avail_q};
            default:      rdata <= '0;
        endcase
    end

    assign sd_cmd.sector = sector_q;
    assign sd_cmd.start  = start_q;

endmodule

// File: logic/char_io_unit.sv
`timescale 1ns/1ns

module char_io_unit import board_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  dec_req_t    dec,
    input  key_in_t     key_in,
    input  logic        irq_ack,
    output logic [3:0]  irq_vector,
    output uart_out_t   uart_out,
    output logic [31:0] rdata
);

    key_in_t    key_q;
    logic [7:0] ascii_q;
    logic       uart_valid_q;
    logic [7:0] uart_data_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_q        <= '0;
            ascii_q      <= '0;
            irq_vector   <= '0;
            uart_valid_q <= 1'b0;
        end else begin
            // Keyboard event goes through one stage before the latch
            key_q <= key_in;
            if (key_q.valid) begin
                ascii_q <= key_q.ascii;
            end
            // Acknowledge wins over a new key
            if (irq_ack && irq_vector != 4'd0) begin
                irq_vector <= '0;
            end else if (key_q.valid && key_q.ascii != 8'd0) begin
                irq_vector <= KEY_IRQ;
            end
            uart_valid_q <= dec.write && (dec.region == REG_UART);
        end
    end

    always_ff @(posedge CLOCK_50) begin
        uart_data_q <= dec.wdata[7:0];
        rdata       <= (dec.region == REG_KEY) ? {24'd0, ascii_q} : 32'd0;
    end

    assign uart_out.valid = uart_valid_q;
    assign uart_out.data  = uart_data_q;

endmodule

// File: logic/read_response.sv
`timescale 1ns/1ns

module read_response import board_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  dec_req_t    dec,
    input  logic [31:0] ram_data,
    input  logic [31:0] sd_data,
    input  logic [31:0] char_data,
    output bus_rsp_t    bus_rsp
);

    region_e     region_q;
    logic [1:0]  lane_q;
    load_kind_e  kind_q;
    logic        read_q;
    logic [31:0] shifted;
    logic [31:0] ram_ext;
    logic [31:0] sel_data;
    logic [31:0] rdata_q;
    logic        done_q;

    // Aligned with the device read registers
    always_ff @(posedge CLOCK_50) begin
        region_q <= dec.region;
        lane_q   <= dec.lane;
        kind_q   <= dec.kind;
    end

    // Byte lane shift, then width and sign
    always_comb begin
        shifted = ram_data >> {lane_q, 3'b000};
        case (kind_q)
            LOAD_B:  ram_ext = {{24{shifted[7]}}, shifted[7:0]};
            LOAD_BU: ram_ext = {24'd0, shifted[7:0]};
            LOAD_H:  ram_ext = {{16{shifted[15]}}, shifted[15:0]};
            LOAD_HU: ram_ext = {16'd0, shifted[15:0]};
            default: ram_ext = shifted;
        endcase
    end

    always_comb begin
        case (region_q)
            REG_RAM:      sel_data = ram_ext;
            REG_KEY:      sel_data = char_data;
            REG_SD_BUF,
            REG_SD_READY,
            REG_SD_AVAIL: sel_data = sd_data;
            // Unmapped and write-only addresses read as zero
            default:      sel_data = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            read_q <= dec.read;
            done_q <= read_q;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        rdata_q <= sel_data;
    end

    assign bus_rsp.rdata = rdata_q;
    assign bus_rsp.done  = done_q;

endmodule

// File: logic/board_bus.sv
`timescale 1ns/1ns

module board_bus import board_bus_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    // Requester
    input  bus_req_t   bus_req,
    output bus_rsp_t   bus_rsp,
    // Keyboard
    input  key_in_t    key_in,
    // SD controller
    input  sd_in_t     sd_in,
    output sd_cmd_t    sd_cmd,
    // Console
    output uart_out_t  uart_out,
    // Interrupt
    output logic [3:0] irq_vector,
    input  logic       irq_ack
);

    dec_req_t    dec;
    logic [31:0] ram_data;
    logic [31:0] sd_data;
    logic [31:0] char_data;

    bus_decoder bus_decoder_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus_req  (bus_req),
        .dec      (dec)
    );

    word_ram word_ram_i (
        .CLOCK_50 (CLOCK_50),
        .dec      (dec),
        .rdata    (ram_data)
    );

    sd_sector_buffer sd_sector_buffer_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .dec      (dec),
        .sd_in    (sd_in),
        .sd_cmd   (sd_cmd),
        .rdata    (sd_data)
    );

    char_io_unit char_io_unit_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .dec        (dec),
        .key_in     (key_in),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector),
        .uart_out   (uart_out),
        .rdata      (char_data)
    );

    // Responses leave in request order, two edges after the strobe
    read_response read_response_i (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .dec       (dec),
        .ram_data  (ram_data),
        .sd_data   (sd_data),
        .char_data (char_data),
        .bus_rsp   (bus_rsp)
    );

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
    output logic CLOCK_50,
    output logic KEY0
);

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    // Reset held low for 16 rising edges
    initial begin
        KEY0 = 1'b0;
        repeat (16) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

// File: bench/bus_checker.sv
`timescale 1ns/1ns

module bus_checker import board_bus_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  bus_req_t   bus_req,
    input  bus_rsp_t   bus_rsp,
    input  key_in_t    key_in,
    input  sd_in_t     sd_in,
    input  sd_cmd_t    sd_cmd,
    input  uart_out_t  uart_out,
    input  logic [3:0] irq_vector,
    input  logic       irq_ack,
    output int         mismatches,
    output int         failures,
    output int         pending
);

    typedef struct packed {
        logic [31:0] data;
        logic [31:0] cyc;
    } expect_t;

    logic [31:0] ram_m [RAM_WORDS];
    logic [7:0]  buf_m [SD_BUF_BYTES];
    logic [8:0]  idx_m;
    logic        avail_m;
    logic [31:0] sector_m;
    logic [7:0]  ascii_m;
    key_in_t     key_m;
    logic [3:0]  irq_m;
    logic        start_m;
    logic        uart_v_m;
    logic [7:0]  uart_d_m;
    bus_req_t    req_d;
    logic [31:0] req_cyc;
    logic [31:0] cyc;
    expect_t     exp_q[$];
    expect_t     ent;
    expect_t     head;

    // Shift to the byte lane, then width and sign by load kind
    function automatic logic [31:0] extend_load(logic [31:0] word, logic [1:0] lane,
                                                load_kind_e kind);
        logic [31:0] s;
        s = word >> (8 * lane);
        case (kind)
            LOAD_B:  return {{24{s[7]}}, s[7:0]};
            LOAD_BU: return {24'd0, s[7:0]};
            LOAD_H:  return {{16{s[15]}}, s[15:0]};
            LOAD_HU: return {16'd0, s[15:0]};
            default: return s;
        endcase
    endfunction

    function automatic logic in_ram(logic [31:0] addr);
        return addr >= RAM_BASE && addr < RAM_BASE + RAM_WORDS * 4;
    endfunction

    function automatic logic in_sd_buf(logic [31:0] addr);
        return addr >= SD_BUF_BASE && addr < SD_BUF_BASE + SD_BUF_BYTES;
    endfunction

    function automatic logic [31:0] model_read(bus_req_t r);
        if (in_ram(r.addr)) begin
            return extend_load(ram_m[10'((r.addr - RAM_BASE) >> 2)], r.addr[1:0], r.kind);
        end
        if (in_sd_buf(r.addr)) begin
            return {24'd0, buf_m[9'(r.addr - SD_BUF_BASE)]};
        end
        case (r.addr)
            KEY_ADDR:     return {24'd0, ascii_m};
            SD_READY_REG: return {31'd0, sd_in.ready};
            SD_AVAIL_REG: return {31'd0, avail_m};
            default:      return 32'd0;
        endcase
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
        $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
        mismatches++;
    endtask

    task automatic flag_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        failures++;
    endtask

    initial begin
        mismatches = 0;
        failures   = 0;
        pending    = 0;
    end

    // Model steps in the same order the device registers see their inputs
    always @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            idx_m    = '0;
            avail_m  = 1'b0;
            sector_m = '0;
            ascii_m  = '0;
            key_m    = '0;
            irq_m    = '0;
            start_m  = 1'b0;
            uart_v_m = 1'b0;
            req_d    = '0;
            req_cyc  = '0;
            cyc      = '0;
        end else begin
            cyc = cyc + 32'd1;
            if (req_d.read) begin
                ent.data = model_read(req_d);
                ent.cyc  = req_cyc;
                exp_q.push_back(ent);
            end
            start_m  = req_d.write && req_d.addr == SD_READ_REG;
            uart_v_m = req_d.write && req_d.addr == UART_ADDR;
            if (uart_v_m) begin
                uart_d_m = req_d.wdata[7:0];
            end
            if (req_d.write && in_ram(req_d.addr)) begin
                ram_m[10'((req_d.addr - RAM_BASE) >> 2)] = req_d.wdata;
            end
            if (req_d.write && req_d.addr == SD_ADDR_REG) begin
                sector_m = req_d.wdata;
            end
            if (start_m) begin
                avail_m = 1'b0;
                idx_m   = '0;
            end else if (sd_in.byte_valid) begin
                buf_m[idx_m] = sd_in.byte_data;
                if (idx_m == 9'(SD_BUF_BYTES - 1)) begin
                    idx_m   = '0;
                    avail_m = 1'b1;
                end else begin
                    idx_m = idx_m + 9'd1;
                end
            end
            if (key_m.valid) begin
                ascii_m = key_m.ascii;
            end
            if (irq_ack && irq_m != 4'd0) begin
                irq_m = '0;
            end else if (key_m.valid && key_m.ascii != 8'd0) begin
                irq_m = KEY_IRQ;
            end
            key_m   = key_in;
            req_d   = bus_req;
            req_cyc = cyc;
        end
    end

    // Outputs are compared half a cycle after the edge
    always @(negedge CLOCK_50) begin
        if (KEY0) begin
            if (irq_vector !== irq_m) begin
                flag_mismatch("irq_vector", 32'(irq_m), 32'(irq_vector));
            end
            if (sd_cmd.start !== start_m) begin
                flag_mismatch("sd_cmd.start", 32'(start_m), 32'(sd_cmd.start));
            end else if (start_m && sd_cmd.sector !== sector_m) begin
                flag_mismatch("sd_cmd.sector", sector_m, sd_cmd.sector);
            end
            if (uart_out.valid !== uart_v_m) begin
                flag_mismatch("uart_out.valid", 32'(uart_v_m), 32'(uart_out.valid));
            end else if (uart_v_m && uart_out.data !== uart_d_m) begin
                flag_mismatch("uart_out.data", 32'(uart_d_m), 32'(uart_out.data));
            end
            if (bus_rsp.done === 1'b1) begin
                if (exp_q.size() == 0) begin
                    flag_failure("done was raised with no read pending");
                end else begin
                    head = exp_q.pop_front();
                    if (cyc - head.cyc != 32'd2) begin
                        flag_failure($sformatf("done came %0d cycles after the read strobe",
                                               cyc - head.cyc));
                    end
                    if (bus_rsp.rdata !== head.data) begin
                        flag_mismatch("bus_rsp.rdata", head.data, bus_rsp.rdata);
                    end
                end
            end else if (bus_rsp.done !== 1'b0) begin
                flag_failure("done is unknown");
            end else if (exp_q.size() != 0 && cyc - exp_q[0].cyc >= 32'd2) begin
                flag_failure("a read strobe got no done in time");
                head = exp_q.pop_front();
            end
            pending = exp_q.size();
        end
    end

endmodule

// File: bench/board_bus_tb.sv
`timescale 1ns/1ns

module board_bus_tb import board_bus_pkg::*; ();

    localparam int RAND_OPS = 1500;
    localparam int RAM_INIT = 64;
    localparam int FILLS    = 2;
    // Fill gaps are at most 3 idle cycles per byte, plus the readback of every byte
    localparam int TIMEOUT  = RAND_OPS + RAM_INIT
                            + FILLS * (SD_BUF_BYTES * 4 + SD_BUF_BYTES + 16) + 1000;

    logic        CLOCK_50;
    logic        KEY0;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    key_in_t     key_in;
    sd_in_t      sd_in;
    sd_cmd_t     sd_cmd;
    uart_out_t   uart_out;
    logic [3:0]  irq_vector;
    logic        irq_ack;
    int          mismatches;
    int          failures;
    int          pending;
    int          cycles;

    clock_gen clock_gen_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    board_bus board_bus_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .key_in     (key_in),
        .sd_in      (sd_in),
        .sd_cmd     (sd_cmd),
        .uart_out   (uart_out),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    bus_checker bus_checker_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .key_in     (key_in),
        .sd_in      (sd_in),
        .sd_cmd     (sd_cmd),
        .uart_out   (uart_out),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack),
        .mismatches (mismatches),
        .failures   (failures),
        .pending    (pending)
    );

    task automatic step();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic write_bus(input logic [31:0] addr, input logic [31:0] data);
        bus_req.addr  = addr;
        bus_req.wdata = data;
        bus_req.write = 1'b1;
        step();
        bus_req.write = 1'b0;
    endtask

    task automatic read_bus(input logic [31:0] addr, input load_kind_e kind);
        bus_req.addr = addr;
        bus_req.kind = kind;
        bus_req.read = 1'b1;
        step();
        bus_req.read = 1'b0;
    endtask

    function automatic load_kind_e pick_kind();
        case ($urandom % 5)
            0:       return LOAD_B;
            1:       return LOAD_H;
            2:       return LOAD_BU;
            3:       return LOAD_HU;
            default: return LOAD_W;
        endcase
    endfunction

    function automatic logic [31:0] pick_unmapped();
        case ($urandom % 4)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_2000;
            2:       return 32'h0000_E200;
            default: return 32'h0000_F018;
        endcase
    endfunction

    // Sector request, byte stream with gaps, then readback of the whole buffer
    task automatic fill_sector();
        sd_in.ready = 1'b1;
        write_bus(SD_ADDR_REG, $urandom);
        write_bus(SD_READ_REG, 32'd0);
        read_bus(SD_AVAIL_REG, LOAD_W);
        for (int i = 0; i < SD_BUF_BYTES; i++) begin
            repeat ($urandom % 4) step();
            sd_in.byte_valid = 1'b1;
            sd_in.byte_data  = 8'($urandom);
            step();
            sd_in.byte_valid = 1'b0;
        end
        step();
        read_bus(SD_AVAIL_REG, LOAD_W);
        for (int i = 0; i < SD_BUF_BYTES; i++) begin
            read_bus(SD_BUF_BASE + 32'(i), LOAD_W);
        end
    endtask

    // Keyboard, ack and SD inputs change alongside bus traffic
    task automatic random_side();
        key_in.valid     = ($urandom % 16) == 0;
        key_in.ascii     = (($urandom % 4) == 0) ? 8'd0 : 8'($urandom);
        irq_ack          = ($urandom % 6) == 0;
        sd_in.byte_valid = ($urandom % 20) == 0;
        sd_in.byte_data  = 8'($urandom);
        if (($urandom % 10) == 0) begin
            sd_in.ready = ~sd_in.ready;
        end
    endtask

    task automatic random_op();
        int unsigned r;
        logic [31:0] ram_addr;
        r        = $urandom % 100;
        ram_addr = RAM_BASE + 32'(($urandom % RAM_INIT) * 4);
        if (r < 27) begin
            write_bus(ram_addr, $urandom);
        end else if (r < 55) begin
            read_bus(ram_addr + 32'($urandom % 4), pick_kind());
        end else if (r < 63) begin
            read_bus(KEY_ADDR, LOAD_W);
        end else if (r < 68) begin
            write_bus(UART_ADDR, $urandom);
        end else if (r < 72) begin
            write_bus(SD_ADDR_REG, $urandom);
        end else if (r < 73) begin
            write_bus(SD_READ_REG, $urandom);
        end else if (r < 78) begin
            read_bus(SD_READY_REG, LOAD_W);
        end else if (r < 83) begin
            read_bus(SD_AVAIL_REG, LOAD_W);
        end else if (r < 89) begin
            read_bus(SD_BUF_BASE + 32'($urandom % SD_BUF_BYTES), LOAD_W);
        end else if (r < 94) begin
            read_bus(pick_unmapped(), LOAD_W);
        end else begin
            case ($urandom % 4)
                0:       write_bus(KEY_ADDR, $urandom);
                1:       write_bus(SD_READY_REG, $urandom);
                2:       write_bus(SD_AVAIL_REG, $urandom);
                default: write_bus(pick_unmapped(), $urandom);
            endcase
        end
    endtask

    initial begin
        bus_req  = '0;
        key_in   = '0;
        sd_in    = '0;
        irq_ack  = 1'b0;
        void'($urandom(64574));
        @(posedge KEY0);
        step();
        for (int i = 0; i < RAM_INIT; i++) begin
            write_bus(RAM_BASE + 32'(i * 4), $urandom);
        end
        fill_sector();
        repeat (RAND_OPS) begin
            random_side();
            random_op();
            key_in.valid     = 1'b0;
            irq_ack          = 1'b0;
            sd_in.byte_valid = 1'b0;
        end
        fill_sector();
        repeat (4) step();
        while (pending != 0) step();
        $display("Checks complete: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    always @(posedge CLOCK_50) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Testbench failed");
            $finish;
        end
    end

    initial cycles = 0;

endmodule

// File: sim.f
logic/board_bus_pkg.sv
logic/bus_decoder.sv
logic/word_ram.sv
logic/sd_sector_buffer.sv
logic/char_io_unit.sv
logic/read_response.sv
logic/board_bus.sv
bench/clock_gen.sv
bench/bus_checker.sv
bench/board_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f sim.f \
    --top-module board_bus_tb --Mdir obj_dir -o board_bus_sim
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

./obj_dir/board_bus_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi

cat sim.log
if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0
